//--- hw/router_pkg.sv
`default_nettype none

package router_pkg;

    // command and data widths
    localparam int ADDR = 32;
    localparam int LEN = 4;
    localparam int DATA = 32;

    // topology
    localparam int INPUTS = 2;
    localparam int INPUTSB = 1;
    localparam int OUTPUTS = 3;
    localparam int OUTPUTSB = 2;

    // routing record queue between command and data paths
    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_PTRB = $clog2(FIFO_DEPTH);

    // address map, index 0 is slave 0
    localparam logic [OUTPUTS-1:0][ADDR-1:0] BASES = {
        32'h8000_0000,
        32'h4000_0000,
        32'h0000_0000
    };

    // offset bits kept when a command is forwarded
    localparam logic [OUTPUTS-1:0][ADDR-1:0] OFFSETS = {
        32'h7FFF_FFFF,
        32'h3FFF_FFFF,
        32'h3FFF_FFFF
    };

endpackage

`default_nettype wire

//--- hw/rr_arbiter.sv
`default_nettype none

module rr_arbiter (
    input  wire                              clk,
    input  wire                              rst,
    input  wire  [router_pkg::INPUTS-1:0]    req,
    input  wire                              advance,
    output logic [router_pkg::INPUTS-1:0]    grant
);

    logic [router_pkg::INPUTSB-1:0] ptr;
    logic [router_pkg::INPUTSB-1:0] gnt_idx;

    // first requester at or after the pointer
    always_comb begin
        int idx;
        logic found;
        grant = '0;
        gnt_idx = '0;
        found = 1'b0;
        for (int k = 0; k < router_pkg::INPUTS; k++) begin
            idx = (int'(ptr) + k) % router_pkg::INPUTS;
            if (!found && req[idx]) begin
                grant[idx] = 1'b1;
                gnt_idx = idx[router_pkg::INPUTSB-1:0];
                found = 1'b1;
            end
        end
    end

    // pointer moves just past the master that was served
    always_ff @(posedge clk) begin
        if (rst) begin
            ptr <= '0;
        end else if (advance && |grant) begin
            if (int'(gnt_idx) == router_pkg::INPUTS - 1) begin
                ptr <= '0;
            end else begin
                ptr <= gnt_idx + 1'b1;
            end
        end
    end

    grant_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(grant))
        else $error("arbiter grant %b not one-hot", grant);

    grant_to_requester: assert property (@(posedge clk) disable iff (rst)
        (grant & ~req) == '0)
        else $error("grant %b without request %b", grant, req);

endmodule

`default_nettype wire

//--- hw/address_decoder.sv
`default_nettype none

module address_decoder (
    input  wire  [router_pkg::ADDR-1:0]      addr,
    output logic [router_pkg::OUTPUTS-1:0]   match
);

    // a slave hits when the address outside its offset field equals its base
    always_comb begin
        for (int j = 0; j < router_pkg::OUTPUTS; j++) begin
            match[j] = (addr & ~router_pkg::OFFSETS[j]) == router_pkg::BASES[j];
        end
    end

    // map covers the whole space, so every known address hits one slave
    always_comb begin
        if (!$isunknown(addr)) begin
            assert ($onehot(match))
                else $error("address %h decodes to %b", addr, match);
        end
    end

endmodule

`default_nettype wire

//--- hw/router_command.sv
`default_nettype none

module router_command (
    input  wire                                                      clk,
    input  wire                                                      rst,

    input  wire  [router_pkg::INPUTS-1:0]                            in_valid,
    output logic [router_pkg::INPUTS-1:0]                            in_ready,
    input  wire  [router_pkg::INPUTS-1:0][router_pkg::ADDR-1:0]      in_addr,
    input  wire  [router_pkg::INPUTS-1:0][router_pkg::LEN-1:0]       in_len,

    output logic [router_pkg::OUTPUTS-1:0]                           out_valid,
    input  wire  [router_pkg::OUTPUTS-1:0]                           out_ready,
    output logic [router_pkg::OUTPUTS-1:0][router_pkg::ADDR-1:0]     out_addr,
    output logic [router_pkg::OUTPUTS-1:0][router_pkg::LEN-1:0]      out_len,
    output logic [router_pkg::OUTPUTS-1:0][router_pkg::INPUTSB-1:0]  out_src,

    input  wire                                                      cmd_full,
    output logic                                                     cmd_push,
    output logic [router_pkg::INPUTSB-1:0]                           cmd_src,
    output logic [router_pkg::OUTPUTSB-1:0]                          cmd_dst,
    output logic [router_pkg::LEN-1:0]                               cmd_len
);

    logic [router_pkg::INPUTS-1:0][router_pkg::OUTPUTS-1:0] in_match;
    logic [router_pkg::OUTPUTS-1:0]  slot_free;
    logic [router_pkg::INPUTS-1:0]   req;
    logic [router_pkg::INPUTS-1:0]   grant;
    logic [router_pkg::INPUTSB-1:0]  src_idx;
    logic [router_pkg::OUTPUTSB-1:0] dst_idx;
    logic [router_pkg::OUTPUTS-1:0]  dst_match;
    logic [router_pkg::ADDR-1:0]     arb_addr;
    logic [router_pkg::LEN-1:0]      arb_len;

    // each master's head command is decoded up front
    for (genvar i = 0; i < router_pkg::INPUTS; i++) begin : g_dec
        address_decoder i_address_decoder (
            .addr  (in_addr[i]),
            .match (in_match[i])
        );
    end

    // slot can take a command if empty or drained this cycle
    assign slot_free = ~out_valid | out_ready;

    // only masters whose target can accept compete, so a busy slave
    // does not hold up traffic to the others
    always_comb begin
        for (int i = 0; i < router_pkg::INPUTS; i++) begin
            req[i] = in_valid[i] && |(in_match[i] & slot_free) && !cmd_full;
        end
    end

    rr_arbiter i_rr_arbiter (
        .clk     (clk),
        .rst     (rst),
        .req     (req),
        .advance (cmd_push),
        .grant   (grant)
    );

    // granted master's command
    always_comb begin
        src_idx = '0;
        arb_addr = in_addr[0];
        arb_len = in_len[0];
        dst_match = in_match[0];
        for (int i = 0; i < router_pkg::INPUTS; i++) begin
            if (grant[i]) begin
                src_idx = i[router_pkg::INPUTSB-1:0];
                arb_addr = in_addr[i];
                arb_len = in_len[i];
                dst_match = in_match[i];
            end
        end
    end

    always_comb begin
        dst_idx = '0;
        for (int j = 0; j < router_pkg::OUTPUTS; j++) begin
            if (dst_match[j]) begin
                dst_idx = j[router_pkg::OUTPUTSB-1:0];
            end
        end
    end

    assign in_ready = grant;
    assign cmd_push = |grant;
    assign cmd_src = src_idx;
    assign cmd_dst = dst_idx;
    assign cmd_len = arb_len;

    // per-slave output slots
    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= '0;
        end else begin
            for (int j = 0; j < router_pkg::OUTPUTS; j++) begin
                if (out_ready[j]) begin
                    out_valid[j] <= 1'b0;
                end
                if (cmd_push && dst_match[j]) begin
                    out_valid[j] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int j = 0; j < router_pkg::OUTPUTS; j++) begin
            if (cmd_push && dst_match[j]) begin
                out_addr[j] <= arb_addr & router_pkg::OFFSETS[j];
                out_len[j] <= arb_len;
                out_src[j] <= src_idx;
            end
        end
    end

    no_push_when_full: assert property (@(posedge clk) disable iff (rst)
        cmd_push |-> !cmd_full)
        else $error("record pushed into full FIFO");

    // a stalled slot keeps its command until the slave takes it
    for (genvar j = 0; j < router_pkg::OUTPUTS; j++) begin : g_hold
        slot_hold: assert property (@(posedge clk) disable iff (rst)
            out_valid[j] && !out_ready[j] |=>
                out_valid[j] && $stable(out_addr[j]) && $stable(out_src[j]))
            else $error("slave %0d command changed while stalled", j);
    end

endmodule

`default_nettype wire

//--- hw/command_fifo.sv
`default_nettype none

module command_fifo (
    input  wire                              clk,
    input  wire                              rst,
    input  wire                              push,
    input  wire  [router_pkg::INPUTSB-1:0]   push_src,
    input  wire  [router_pkg::OUTPUTSB-1:0]  push_dst,
    input  wire  [router_pkg::LEN-1:0]       push_len,
    output logic                             full,
    output logic                             rec_valid,
    output logic [router_pkg::INPUTSB-1:0]   rec_src,
    output logic [router_pkg::OUTPUTSB-1:0]  rec_dst,
    output logic [router_pkg::LEN-1:0]       rec_len,
    input  wire                              pop
);

    logic [router_pkg::INPUTSB-1:0]  src_mem [router_pkg::FIFO_DEPTH];
    logic [router_pkg::OUTPUTSB-1:0] dst_mem [router_pkg::FIFO_DEPTH];
    logic [router_pkg::LEN-1:0]      len_mem [router_pkg::FIFO_DEPTH];

    logic [router_pkg::FIFO_PTRB-1:0] wr_ptr;
    logic [router_pkg::FIFO_PTRB-1:0] rd_ptr;
    logic [router_pkg::FIFO_PTRB:0]   count;

    // depth is a power of two, so the top count bit means full
    assign full = count[router_pkg::FIFO_PTRB];
    assign rec_valid = count != '0;

    assign rec_src = src_mem[rd_ptr];
    assign rec_dst = dst_mem[rd_ptr];
    assign rec_len = len_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            src_mem[wr_ptr] <= push_src;
            dst_mem[wr_ptr] <= push_dst;
            len_mem[wr_ptr] <= push_len;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    no_overflow: assert property (@(posedge clk) disable iff (rst) push |-> !full)
        else $error("push into full command FIFO");

    no_underflow: assert property (@(posedge clk) disable iff (rst) pop |-> rec_valid)
        else $error("pop from empty command FIFO");

endmodule

`default_nettype wire

//--- hw/router_wdata.sv
`default_nettype none

module router_wdata (
    input  wire                                                      clk,
    input  wire                                                      rst,

    input  wire                                                      rec_valid,
    input  wire  [router_pkg::INPUTSB-1:0]                           rec_src,
    input  wire  [router_pkg::OUTPUTSB-1:0]                          rec_dst,
    input  wire  [router_pkg::LEN-1:0]                               rec_len,
    output logic                                                     rec_pop,

    input  wire  [router_pkg::INPUTS-1:0]                            wi_valid,
    output logic [router_pkg::INPUTS-1:0]                            wi_ready,
    input  wire  [router_pkg::INPUTS-1:0][router_pkg::DATA-1:0]      wi_data,

    output logic [router_pkg::OUTPUTS-1:0]                           wo_valid,
    input  wire  [router_pkg::OUTPUTS-1:0]                           wo_ready,
    output logic [router_pkg::OUTPUTS-1:0][router_pkg::DATA-1:0]     wo_data,
    output logic [router_pkg::OUTPUTS-1:0]                           wo_last
);

    logic [router_pkg::LEN-1:0] beat;
    logic src_valid;
    logic dst_ready;
    logic last_beat;
    logic beat_xfer;

    // selected pair, idle when no record is at the head
    assign src_valid = rec_valid && wi_valid[rec_src];
    assign dst_ready = rec_valid && wo_ready[rec_dst];
    assign last_beat = beat == rec_len;
    assign beat_xfer = src_valid && dst_ready;

    always_comb begin
        for (int i = 0; i < router_pkg::INPUTS; i++) begin
            wi_ready[i] = dst_ready && int'(rec_src) == i;
        end
    end

    always_comb begin
        for (int j = 0; j < router_pkg::OUTPUTS; j++) begin
            wo_valid[j] = src_valid && int'(rec_dst) == j;
            wo_last[j] = rec_valid && last_beat && int'(rec_dst) == j;
            wo_data[j] = wi_data[rec_src];
        end
    end

    // record retires with its last beat
    assign rec_pop = beat_xfer && last_beat;

    always_ff @(posedge clk) begin
        if (rst) begin
            beat <= '0;
        end else if (beat_xfer) begin
            if (last_beat) begin
                beat <= '0;
            end else begin
                beat <= beat + 1'b1;
            end
        end
    end

    // counter stays inside the burst at the head
    beat_in_range: assert property (@(posedge clk) disable iff (rst)
        rec_valid |-> beat <= rec_len)
        else $error("beat %0d past burst length %0d", beat, rec_len);

endmodule

`default_nettype wire

//--- hw/axi_write_router.sv
`default_nettype none

module axi_write_router (
    input  wire                                                      clk,
    input  wire                                                      rst,

    input  wire  [router_pkg::INPUTS-1:0]                            in_valid,
    output wire  [router_pkg::INPUTS-1:0]                            in_ready,
    input  wire  [router_pkg::INPUTS-1:0][router_pkg::ADDR-1:0]      in_addr,
    input  wire  [router_pkg::INPUTS-1:0][router_pkg::LEN-1:0]       in_len,

    output wire  [router_pkg::OUTPUTS-1:0]                           out_valid,
    input  wire  [router_pkg::OUTPUTS-1:0]                           out_ready,
    output wire  [router_pkg::OUTPUTS-1:0][router_pkg::ADDR-1:0]     out_addr,
    output wire  [router_pkg::OUTPUTS-1:0][router_pkg::LEN-1:0]      out_len,
    output wire  [router_pkg::OUTPUTS-1:0][router_pkg::INPUTSB-1:0]  out_src,

    input  wire  [router_pkg::INPUTS-1:0]                            wi_valid,
    output wire  [router_pkg::INPUTS-1:0]                            wi_ready,
    input  wire  [router_pkg::INPUTS-1:0][router_pkg::DATA-1:0]      wi_data,

    output wire  [router_pkg::OUTPUTS-1:0]                           wo_valid,
    input  wire  [router_pkg::OUTPUTS-1:0]                           wo_ready,
    output wire  [router_pkg::OUTPUTS-1:0][router_pkg::DATA-1:0]     wo_data,
    output wire  [router_pkg::OUTPUTS-1:0]                           wo_last
);

    wire                             cmd_full;
    wire                             cmd_push;
    wire [router_pkg::INPUTSB-1:0]   cmd_src;
    wire [router_pkg::OUTPUTSB-1:0]  cmd_dst;
    wire [router_pkg::LEN-1:0]       cmd_len;

    wire                             rec_valid;
    wire [router_pkg::INPUTSB-1:0]   rec_src;
    wire [router_pkg::OUTPUTSB-1:0]  rec_dst;
    wire [router_pkg::LEN-1:0]       rec_len;
    wire                             rec_pop;

    router_command i_router_command (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_addr   (in_addr),
        .in_len    (in_len),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_addr  (out_addr),
        .out_len   (out_len),
        .out_src   (out_src),
        .cmd_full  (cmd_full),
        .cmd_push  (cmd_push),
        .cmd_src   (cmd_src),
        .cmd_dst   (cmd_dst),
        .cmd_len   (cmd_len)
    );

    command_fifo i_command_fifo (
        .clk       (clk),
        .rst       (rst),
        .push      (cmd_push),
        .push_src  (cmd_src),
        .push_dst  (cmd_dst),
        .push_len  (cmd_len),
        .full      (cmd_full),
        .rec_valid (rec_valid),
        .rec_src   (rec_src),
        .rec_dst   (rec_dst),
        .rec_len   (rec_len),
        .pop       (rec_pop)
    );

    router_wdata i_router_wdata (
        .clk       (clk),
        .rst       (rst),
        .rec_valid (rec_valid),
        .rec_src   (rec_src),
        .rec_dst   (rec_dst),
        .rec_len   (rec_len),
        .rec_pop   (rec_pop),
        .wi_valid  (wi_valid),
        .wi_ready  (wi_ready),
        .wi_data   (wi_data),
        .wo_valid  (wo_valid),
        .wo_ready  (wo_ready),
        .wo_data   (wo_data),
        .wo_last   (wo_last)
    );

endmodule

`default_nettype wire

//--- test/tb_axi_write_router.sv
`default_nettype none

module tb_axi_write_router;

    localparam int MAX_CMDS = 32;
    localparam int DRIVE_DELAY = 2;

    logic clk;
    logic rst;
    logic [router_pkg::INPUTS-1:0]                            in_valid;
    wire  [router_pkg::INPUTS-1:0]                            in_ready;
    logic [router_pkg::INPUTS-1:0][router_pkg::ADDR-1:0]      in_addr;
    logic [router_pkg::INPUTS-1:0][router_pkg::LEN-1:0]       in_len;
    wire  [router_pkg::OUTPUTS-1:0]                           out_valid;
    logic [router_pkg::OUTPUTS-1:0]                           out_ready;
    wire  [router_pkg::OUTPUTS-1:0][router_pkg::ADDR-1:0]     out_addr;
    wire  [router_pkg::OUTPUTS-1:0][router_pkg::LEN-1:0]      out_len;
    wire  [router_pkg::OUTPUTS-1:0][router_pkg::INPUTSB-1:0]  out_src;
    logic [router_pkg::INPUTS-1:0]                            wi_valid;
    wire  [router_pkg::INPUTS-1:0]                            wi_ready;
    logic [router_pkg::INPUTS-1:0][router_pkg::DATA-1:0]      wi_data;
    wire  [router_pkg::OUTPUTS-1:0]                           wo_valid;
    logic [router_pkg::OUTPUTS-1:0]                           wo_ready;
    wire  [router_pkg::OUTPUTS-1:0][router_pkg::DATA-1:0]     wo_data;
    wire  [router_pkg::OUTPUTS-1:0]                           wo_last;

    // pattern file, four words per command
    logic [31:0] pat [4*MAX_CMDS];
    logic [router_pkg::INPUTSB-1:0] p_src [MAX_CMDS];
    logic [router_pkg::ADDR-1:0]    p_addr [MAX_CMDS];
    logic [router_pkg::LEN-1:0]     p_len [MAX_CMDS];
    logic [router_pkg::DATA-1:0]    p_seed [MAX_CMDS];
    int n_cmds;
    int total_beats;

    int mlist [router_pkg::INPUTS][$];
    int exp_cmd [router_pkg::OUTPUTS][$];
    int exp_data [router_pkg::OUTPUTS][$];
    int acc_idx [router_pkg::INPUTS];
    int beat_cnt [router_pkg::OUTPUTS];
    int accepted;
    int bursts_done;
    int cmds_seen;
    int beats_seen;
    int cycles;
    int limit;
    logic fifo_full_seen;

    axi_write_router i_axi_write_router (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_addr   (in_addr),
        .in_len    (in_len),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_addr  (out_addr),
        .out_len   (out_len),
        .out_src   (out_src),
        .wi_valid  (wi_valid),
        .wi_ready  (wi_ready),
        .wi_data   (wi_data),
        .wo_valid  (wo_valid),
        .wo_ready  (wo_ready),
        .wo_data   (wo_data),
        .wo_last   (wo_last)
    );

    always #20 clk = ~clk;

    // address map: slave 0 below 0x4000_0000, slave 1 below 0x8000_0000, slave 2 above
    function automatic int slave_of(input logic [router_pkg::ADDR-1:0] a);
        if (a >= 32'h8000_0000) begin
            return 2;
        end
        if (a >= 32'h4000_0000) begin
            return 1;
        end
        return 0;
    endfunction

    function automatic logic [router_pkg::ADDR-1:0] local_addr(
        input logic [router_pkg::ADDR-1:0] a
    );
        case (slave_of(a))
            2: return a - 32'h8000_0000;
            1: return a - 32'h4000_0000;
            default: return a;
        endcase
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_cmd(
        input int j,
        input logic [router_pkg::ADDR-1:0]    got_addr,
        input logic [router_pkg::ADDR-1:0]    exp_addr,
        input logic [router_pkg::LEN-1:0]     got_len,
        input logic [router_pkg::LEN-1:0]     exp_len,
        input logic [router_pkg::INPUTSB-1:0] got_src,
        input logic [router_pkg::INPUTSB-1:0] exp_src
    );
        if (got_addr !== exp_addr) begin
            fail_run($sformatf("[FAIL] out_addr[%0d] got %h expected %h", j, got_addr, exp_addr));
        end
        if (got_len !== exp_len) begin
            fail_run($sformatf("[FAIL] out_len[%0d] got %h expected %h", j, got_len, exp_len));
        end
        if (got_src !== exp_src) begin
            fail_run($sformatf("[FAIL] out_src[%0d] got %h expected %h", j, got_src, exp_src));
        end
    endtask

    task automatic check_beat(
        input int j,
        input logic [router_pkg::DATA-1:0] got_data,
        input logic [router_pkg::DATA-1:0] exp_data_word,
        input logic got_last,
        input logic exp_last
    );
        if (got_data !== exp_data_word) begin
            fail_run($sformatf("[FAIL] wo_data[%0d] got %h expected %h",
                j, got_data, exp_data_word));
        end
        if (got_last !== exp_last) begin
            fail_run($sformatf("[FAIL] wo_last[%0d] got %h expected %h", j, got_last, exp_last));
        end
    endtask

    task automatic load_patterns();
        int m;
        // unused entries carry no valid master number
        for (int a = 0; a < 4 * MAX_CMDS; a++) begin
            pat[a] = 32'hDEAD_0000 | a;
        end
        $readmemh("test/router_patterns.txt", pat);
        n_cmds = 0;
        total_beats = 0;
        while (n_cmds < MAX_CMDS && pat[4*n_cmds] < router_pkg::INPUTS) begin
            m = int'(pat[4*n_cmds]);
            p_src[n_cmds] = pat[4*n_cmds][router_pkg::INPUTSB-1:0];
            p_addr[n_cmds] = pat[4*n_cmds+1];
            p_len[n_cmds] = pat[4*n_cmds+2][router_pkg::LEN-1:0];
            p_seed[n_cmds] = pat[4*n_cmds+3];
            mlist[m].push_back(n_cmds);
            total_beats += int'(p_len[n_cmds]) + 1;
            n_cmds++;
        end
        if (n_cmds == 0) begin
            fail_run("no commands found in the pattern file");
        end
        limit = 40 * (total_beats + n_cmds);
    endtask

    task automatic drive_cmds(input int m);
        int k;
        int unsigned gap;
        for (int n = 0; n < mlist[m].size(); n++) begin
            k = mlist[m][n];
            gap = $urandom_range(0, 3);
            repeat (gap) begin
                @(posedge clk);
                #DRIVE_DELAY;
            end
            in_valid[m] = 1'b1;
            in_addr[m] = p_addr[k];
            in_len[m] = p_len[k];
            @(negedge clk);
            while (!in_ready[m]) begin
                @(negedge clk);
            end
            @(posedge clk);
            #DRIVE_DELAY;
            in_valid[m] = 1'b0;
        end
    endtask

    // beats go out in the master's own command order
    task automatic drive_beats(input int m);
        int k;
        for (int n = 0; n < mlist[m].size(); n++) begin
            k = mlist[m][n];
            for (int b = 0; b <= int'(p_len[k]); b++) begin
                wi_valid[m] = 1'b1;
                wi_data[m] = p_seed[k] + b;
                @(negedge clk);
                while (!wi_ready[m]) begin
                    @(negedge clk);
                end
                @(posedge clk);
                #DRIVE_DELAY;
            end
        end
        wi_valid[m] = 1'b0;
    endtask

    // data side held off until the command FIFO has filled once
    task automatic toggle_readies();
        int unsigned r;
        forever begin
            @(posedge clk);
            #DRIVE_DELAY;
            r = $urandom;
            out_ready = r[router_pkg::OUTPUTS-1:0];
            r = $urandom;
            wo_ready = fifo_full_seen ? r[router_pkg::OUTPUTS-1:0] : '0;
        end
    endtask

    task automatic take_inputs();
        int k;
        int j;
        for (int m = 0; m < router_pkg::INPUTS; m++) begin
            if (in_valid[m] && in_ready[m]) begin
                if (acc_idx[m] >= mlist[m].size()) begin
                    fail_run($sformatf("master %0d had more commands accepted than issued", m));
                end
                if (accepted - bursts_done >= router_pkg::FIFO_DEPTH) begin
                    fail_run($sformatf("master %0d command accepted while the FIFO was full",
                        m));
                end
                k = mlist[m][acc_idx[m]];
                acc_idx[m]++;
                j = slave_of(p_addr[k]);
                exp_cmd[j].push_back(k);
                exp_data[j].push_back(k);
                accepted++;
            end
        end
    endtask

    // a slave sees its commands in the order they were accepted
    task automatic take_commands();
        int k;
        for (int j = 0; j < router_pkg::OUTPUTS; j++) begin
            if (out_valid[j] && out_ready[j]) begin
                if (exp_cmd[j].size() == 0) begin
                    fail_run($sformatf("slave %0d got a command with none pending", j));
                end
                k = exp_cmd[j].pop_front();
                check_cmd(j, out_addr[j], local_addr(p_addr[k]), out_len[j], p_len[k],
                    out_src[j], p_src[k]);
                cmds_seen++;
            end
        end
    endtask

    task automatic take_beats();
        int k;
        logic fin;
        for (int j = 0; j < router_pkg::OUTPUTS; j++) begin
            if (wo_valid[j] && wo_ready[j]) begin
                if (exp_data[j].size() == 0) begin
                    fail_run($sformatf("slave %0d got a data beat with no burst pending", j));
                end
                k = exp_data[j][0];
                fin = beat_cnt[j] == int'(p_len[k]);
                check_beat(j, wo_data[j], p_seed[k] + beat_cnt[j], wo_last[j], fin);
                if (fin) begin
                    void'(exp_data[j].pop_front());
                    beat_cnt[j] = 0;
                    bursts_done++;
                end else begin
                    beat_cnt[j]++;
                end
                beats_seen++;
            end
        end
    endtask

    // handshakes are sampled mid-cycle, the transfer happens at the next rising edge
    always @(negedge clk) begin
        if (!rst) begin
            if (|(in_valid & ~in_ready) && accepted - bursts_done == router_pkg::FIFO_DEPTH) begin
                fifo_full_seen = 1'b1;
            end
            take_inputs();
            take_commands();
            take_beats();
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (limit > 0 && cycles >= limit) begin
            fail_run($sformatf("run stalled, not done after %0d cycles", cycles));
        end
    end

    initial begin
        int left;
        clk = 1'b0;
        rst = 1'b1;
        in_valid = '0;
        in_addr = '0;
        in_len = '0;
        out_ready = '0;
        wi_valid = '0;
        wi_data = '0;
        wo_ready = '0;
        fifo_full_seen = 1'b0;
        accepted = 0;
        bursts_done = 0;
        cmds_seen = 0;
        beats_seen = 0;
        cycles = 0;
        limit = 0;
        acc_idx = '{default: 0};
        beat_cnt = '{default: 0};
        void'($urandom(32'h1682_9567));
        load_patterns();
        repeat (5) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;
        fork
            drive_cmds(0);
            drive_cmds(1);
            drive_beats(0);
            drive_beats(1);
            toggle_readies();
        join_none
        wait (cmds_seen == n_cmds && beats_seen == total_beats);
        @(negedge clk);
        left = 0;
        for (int j = 0; j < router_pkg::OUTPUTS; j++) begin
            left += exp_data[j].size();
            left += exp_cmd[j].size();
        end
        if (left == 0 && fifo_full_seen) begin
            $display("test passed");
            $finish;
        end else begin
            fail_run($sformatf("%0d items still expected, FIFO full stall seen: %0d",
                left, fifo_full_seen));
        end
    end

endmodule

`default_nettype wire

//--- axi_write_router.f
hw/router_pkg.sv
hw/rr_arbiter.sv
hw/address_decoder.sv
hw/router_command.sv
hw/command_fifo.sv
hw/router_wdata.sv
hw/axi_write_router.sv
test/tb_axi_write_router.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove build output and the log"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_axi_write_router \
		-f axi_write_router.f --Mdir obj_dir -o sim_tb
	-./obj_dir/sim_tb > sim.log 2>&1
	@cat sim.log
	@grep -qx "test passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- test/router_patterns.txt
// columns: master  address  burst length (beats minus one)  data seed
// first block is short bursts, issued while the data side is still held off
0 00000100 0 a0000000
1 40000200 1 b0000000
0 80000300 0 a0000100
1 00000400 0 b0000100
0 40000500 1 a0000200
1 80000600 0 b0000200
// map edges and longer bursts
0 3ffffff0 3 a0000300
1 7ffffff0 2 b0000300
0 fffffff0 7 a0000400
1 c0001000 f b0000400
// both masters on each slave in turn
0 00002000 2 a0000500
1 00003000 4 b0000500
0 40002000 5 a0000600
1 40003000 1 b0000600
0 80002000 0 a0000700
1 80003000 3 b0000700
// mixed tail, one seed wraps around
0 12345678 6 a0000800
1 9abcdef0 2 ffffffff
0 7fffffff 0 a0000900
1 00000000 1 b0000900
0 deadbeef 4 a0000a00
1 45670000 0 b0000a00
